/* design/decode_pkg.sv */
package decode_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	localparam int        NUM_REGS = 32;
	localparam reg_addr_t LINK_REG = 5'd31;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;

	// function field of SPECIAL
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// rt field of REGIMM
	localparam logic [4:0] RT_BLTZ   = 5'b00000;
	localparam logic [4:0] RT_BGEZ   = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index;
	} j_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} inst_u;

	// order matters, the decoder derives the result class from ranges
	typedef enum logic [5:0] {
		ALU_NOP,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
		ALU_J, ALU_JAL, ALU_JR, ALU_JALR,
		ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ,
		ALU_BGEZ, ALU_BLTZ, ALU_BGEZAL, ALU_BLTZAL
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110
	} alu_sel_e;

	typedef enum logic [3:0] {
		BR_NONE, BR_JUMP, BR_JUMP_REG, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
	} br_kind_e;

	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
	} fwd_t;

	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} wb_t;

	typedef struct packed {
		alu_op_e   aluop;
		alu_sel_e  alusel;
		logic      reg1_read;
		logic      reg2_read;
		reg_addr_t reg1_addr;
		reg_addr_t reg2_addr;
		logic      wreg;
		reg_addr_t wd;
		word_t     imm;
		br_kind_e  br_kind;
		logic      link;
	} dec_ctrl_t;

	typedef struct packed {
		logic  flag;
		word_t addr;
		logic  next_in_delayslot;
	} branch_t;

	typedef struct packed {
		alu_op_e   aluop;
		alu_sel_e  alusel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t wd;
		logic      wreg;
		word_t     link_addr;
		logic      in_delayslot;
	} id_ex_t;

endpackage

/* design/instr_decoder.sv */
module instr_decoder (
	input  decode_pkg::inst_u     inst_i,
	output decode_pkg::dec_ctrl_t ctrl_o
);

	decode_pkg::word_t   imm_zext;
	decode_pkg::word_t   imm_sext;
	decode_pkg::alu_op_e r_op;

	function automatic decode_pkg::alu_op_e special_op(logic [5:0] funct);
		case (funct)
			decode_pkg::FN_SLL:  return decode_pkg::ALU_SLL;
			decode_pkg::FN_SRL:  return decode_pkg::ALU_SRL;
			decode_pkg::FN_SRA:  return decode_pkg::ALU_SRA;
			decode_pkg::FN_SLLV: return decode_pkg::ALU_SLL;
			decode_pkg::FN_SRLV: return decode_pkg::ALU_SRL;
			decode_pkg::FN_SRAV: return decode_pkg::ALU_SRA;
			decode_pkg::FN_AND:  return decode_pkg::ALU_AND;
			decode_pkg::FN_OR:   return decode_pkg::ALU_OR;
			decode_pkg::FN_XOR:  return decode_pkg::ALU_XOR;
			decode_pkg::FN_NOR:  return decode_pkg::ALU_NOR;
			decode_pkg::FN_ADD:  return decode_pkg::ALU_ADD;
			decode_pkg::FN_ADDU: return decode_pkg::ALU_ADDU;
			decode_pkg::FN_SUB:  return decode_pkg::ALU_SUB;
			decode_pkg::FN_SUBU: return decode_pkg::ALU_SUBU;
			decode_pkg::FN_SLT:  return decode_pkg::ALU_SLT;
			decode_pkg::FN_SLTU: return decode_pkg::ALU_SLTU;
			default:             return decode_pkg::ALU_NOP;
		endcase
	endfunction

	function automatic decode_pkg::alu_sel_e class_of(decode_pkg::alu_op_e op);
		if (op inside {[decode_pkg::ALU_AND:decode_pkg::ALU_NOR]})
			return decode_pkg::SEL_LOGIC;
		if (op inside {[decode_pkg::ALU_SLL:decode_pkg::ALU_SRA]})
			return decode_pkg::SEL_SHIFT;
		if (op inside {[decode_pkg::ALU_ADD:decode_pkg::ALU_SLTU]})
			return decode_pkg::SEL_ARITH;
		if (op == decode_pkg::ALU_NOP)
			return decode_pkg::SEL_NOP;
		return decode_pkg::SEL_JUMP_BRANCH;
	endfunction

	assign imm_zext = {16'h0, inst_i.i.imm};
	assign imm_sext = {{16{inst_i.i.imm[15]}}, inst_i.i.imm};
	assign r_op     = special_op(inst_i.r.funct);

	always_comb begin
		ctrl_o           = '0;
		ctrl_o.reg1_addr = inst_i.r.rs;
		ctrl_o.reg2_addr = inst_i.r.rt;
		ctrl_o.wd        = inst_i.r.rd;

		case (inst_i.r.opcode)
			decode_pkg::OP_SPECIAL: begin
				case (inst_i.r.funct)
					// shift by shamt, amount goes out as reg1
					decode_pkg::FN_SLL, decode_pkg::FN_SRL, decode_pkg::FN_SRA: begin
						if (inst_i.r.rs == '0) begin
							ctrl_o.aluop     = r_op;
							ctrl_o.reg2_read = 1'b1;
							ctrl_o.wreg      = 1'b1;
							ctrl_o.imm       = {27'h0, inst_i.r.shamt};
						end
					end
					decode_pkg::FN_JR: begin
						if (inst_i.r.shamt == '0) begin
							ctrl_o.aluop     = decode_pkg::ALU_JR;
							ctrl_o.reg1_read = 1'b1;
							ctrl_o.br_kind   = decode_pkg::BR_JUMP_REG;
						end
					end
					decode_pkg::FN_JALR: begin
						if (inst_i.r.shamt == '0) begin
							ctrl_o.aluop     = decode_pkg::ALU_JALR;
							ctrl_o.reg1_read = 1'b1;
							ctrl_o.wreg      = 1'b1;
							ctrl_o.link      = 1'b1;
							ctrl_o.br_kind   = decode_pkg::BR_JUMP_REG;
						end
					end
					default: begin
						if (inst_i.r.shamt == '0 && r_op != decode_pkg::ALU_NOP) begin
							ctrl_o.aluop     = r_op;
							ctrl_o.reg1_read = 1'b1;
							ctrl_o.reg2_read = 1'b1;
							ctrl_o.wreg      = 1'b1;
						end
					end
				endcase
			end
			decode_pkg::OP_REGIMM: begin
				case (inst_i.i.rt)
					decode_pkg::RT_BLTZ: begin
						ctrl_o.aluop   = decode_pkg::ALU_BLTZ;
						ctrl_o.br_kind = decode_pkg::BR_LTZ;
					end
					decode_pkg::RT_BGEZ: begin
						ctrl_o.aluop   = decode_pkg::ALU_BGEZ;
						ctrl_o.br_kind = decode_pkg::BR_GEZ;
					end
					decode_pkg::RT_BLTZAL: begin
						ctrl_o.aluop   = decode_pkg::ALU_BLTZAL;
						ctrl_o.br_kind = decode_pkg::BR_LTZ;
						ctrl_o.link    = 1'b1;
					end
					decode_pkg::RT_BGEZAL: begin
						ctrl_o.aluop   = decode_pkg::ALU_BGEZAL;
						ctrl_o.br_kind = decode_pkg::BR_GEZ;
						ctrl_o.link    = 1'b1;
					end
					default: ;
				endcase
				ctrl_o.reg1_read = (ctrl_o.aluop != decode_pkg::ALU_NOP);
				// linking forms write r31 whether taken or not
				ctrl_o.wreg = ctrl_o.link;
				if (ctrl_o.link)
					ctrl_o.wd = decode_pkg::LINK_REG;
			end
			decode_pkg::OP_J: begin
				ctrl_o.aluop   = decode_pkg::ALU_J;
				ctrl_o.br_kind = decode_pkg::BR_JUMP;
			end
			decode_pkg::OP_JAL: begin
				ctrl_o.aluop   = decode_pkg::ALU_JAL;
				ctrl_o.br_kind = decode_pkg::BR_JUMP;
				ctrl_o.wreg    = 1'b1;
				ctrl_o.wd      = decode_pkg::LINK_REG;
				ctrl_o.link    = 1'b1;
			end
			decode_pkg::OP_BEQ: begin
				ctrl_o.aluop     = decode_pkg::ALU_BEQ;
				ctrl_o.br_kind   = decode_pkg::BR_EQ;
				ctrl_o.reg1_read = 1'b1;
				ctrl_o.reg2_read = 1'b1;
			end
			decode_pkg::OP_BNE: begin
				ctrl_o.aluop     = decode_pkg::ALU_BNE;
				ctrl_o.br_kind   = decode_pkg::BR_NE;
				ctrl_o.reg1_read = 1'b1;
				ctrl_o.reg2_read = 1'b1;
			end
			decode_pkg::OP_BGTZ: begin
				ctrl_o.aluop     = decode_pkg::ALU_BGTZ;
				ctrl_o.br_kind   = decode_pkg::BR_GTZ;
				ctrl_o.reg1_read = 1'b1;
			end
			decode_pkg::OP_BLEZ: begin
				ctrl_o.aluop     = decode_pkg::ALU_BLEZ;
				ctrl_o.br_kind   = decode_pkg::BR_LEZ;
				ctrl_o.reg1_read = 1'b1;
			end
			decode_pkg::OP_ANDI: begin
				ctrl_o.aluop = decode_pkg::ALU_AND;
				ctrl_o.imm   = imm_zext;
			end
			decode_pkg::OP_ORI: begin
				ctrl_o.aluop = decode_pkg::ALU_OR;
				ctrl_o.imm   = imm_zext;
			end
			decode_pkg::OP_XORI: begin
				ctrl_o.aluop = decode_pkg::ALU_XOR;
				ctrl_o.imm   = imm_zext;
			end
			decode_pkg::OP_LUI: begin
				ctrl_o.aluop = decode_pkg::ALU_OR;
				ctrl_o.imm   = {inst_i.i.imm, 16'h0};
			end
			decode_pkg::OP_ADDI: begin
				ctrl_o.aluop = decode_pkg::ALU_ADD;
				ctrl_o.imm   = imm_sext;
			end
			decode_pkg::OP_ADDIU: begin
				ctrl_o.aluop = decode_pkg::ALU_ADDU;
				ctrl_o.imm   = imm_sext;
			end
			decode_pkg::OP_SLTI: begin
				ctrl_o.aluop = decode_pkg::ALU_SLT;
				ctrl_o.imm   = imm_sext;
			end
			decode_pkg::OP_SLTIU: begin
				ctrl_o.aluop = decode_pkg::ALU_SLTU;
				ctrl_o.imm   = imm_sext;
			end
			default: ;
		endcase

		// opcodes 001xxx are all immediate forms: rs op imm -> rt
		if (inst_i.i.opcode[5:3] == 3'b001) begin
			ctrl_o.reg1_read = 1'b1;
			ctrl_o.wreg      = 1'b1;
			ctrl_o.wd        = inst_i.i.rt;
		end

		ctrl_o.alusel = class_of(ctrl_o.aluop);
	end

endmodule

/* design/operand_select.sv */
module operand_select (
	input  decode_pkg::dec_ctrl_t ctrl_i,
	input  decode_pkg::word_t     rdata1_i,
	input  decode_pkg::word_t     rdata2_i,
	input  decode_pkg::fwd_t      ex_fwd_i,
	input  decode_pkg::fwd_t      mem_fwd_i,
	output decode_pkg::word_t     reg1_o,
	output decode_pkg::word_t     reg2_o
);

	// execute result is newest, so it beats memory
	function automatic decode_pkg::word_t pick_operand(
		logic                  rd_en,
		decode_pkg::reg_addr_t addr,
		decode_pkg::word_t     rdata,
		decode_pkg::word_t     imm,
		decode_pkg::fwd_t      ex,
		decode_pkg::fwd_t      mem
	);
		if (!rd_en)
			return imm;
		if (ex.wreg && ex.wd == addr)
			return ex.wdata;
		if (mem.wreg && mem.wd == addr)
			return mem.wdata;
		return rdata;
	endfunction

	assign reg1_o = pick_operand(ctrl_i.reg1_read, ctrl_i.reg1_addr, rdata1_i,
		ctrl_i.imm, ex_fwd_i, mem_fwd_i);
	assign reg2_o = pick_operand(ctrl_i.reg2_read, ctrl_i.reg2_addr, rdata2_i,
		ctrl_i.imm, ex_fwd_i, mem_fwd_i);

endmodule

/* design/branch_unit.sv */
module branch_unit (
	input  decode_pkg::word_t     pc_i,
	input  decode_pkg::inst_u     inst_i,
	input  decode_pkg::dec_ctrl_t ctrl_i,
	input  decode_pkg::word_t     reg1_i,
	input  decode_pkg::word_t     reg2_i,
	output decode_pkg::branch_t   branch_o,
	output decode_pkg::word_t     link_addr_o
);

	decode_pkg::word_t pc_plus_4;
	decode_pkg::word_t pc_plus_8;
	decode_pkg::word_t br_target;
	decode_pkg::word_t jmp_target;
	decode_pkg::word_t target;
	logic              reg1_zero;
	logic              reg1_neg;
	logic              taken;

	assign pc_plus_4  = pc_i + 32'd4;
	assign pc_plus_8  = pc_i + 32'd8;
	assign br_target  = pc_plus_4 + {{14{inst_i.i.imm[15]}}, inst_i.i.imm, 2'b00};
	// stays inside the current 256MB region
	assign jmp_target = {pc_plus_4[31:28], inst_i.j.index, 2'b00};
	assign reg1_zero  = (reg1_i == '0);
	assign reg1_neg   = reg1_i[31];

	always_comb begin
		target = br_target;
		case (ctrl_i.br_kind)
			decode_pkg::BR_JUMP: begin
				taken  = 1'b1;
				target = jmp_target;
			end
			decode_pkg::BR_JUMP_REG: begin
				taken  = 1'b1;
				target = reg1_i;
			end
			decode_pkg::BR_EQ:  taken = (reg1_i == reg2_i);
			decode_pkg::BR_NE:  taken = (reg1_i != reg2_i);
			decode_pkg::BR_GTZ: taken = !reg1_neg && !reg1_zero;
			decode_pkg::BR_LEZ: taken = reg1_neg || reg1_zero;
			decode_pkg::BR_GEZ: taken = !reg1_neg;
			decode_pkg::BR_LTZ: taken = reg1_neg;
			default:            taken = 1'b0;
		endcase
	end

	always_comb begin
		branch_o.flag              = taken;
		branch_o.addr              = taken ? target : '0;
		branch_o.next_in_delayslot = taken;
	end

	assign link_addr_o = ctrl_i.link ? pc_plus_8 : '0;

endmodule

/* design/reg_file.sv */
module reg_file (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  decode_pkg::wb_t       wb_i,
	input  decode_pkg::reg_addr_t raddr1_i,
	input  decode_pkg::reg_addr_t raddr2_i,
	output decode_pkg::word_t     rdata1_o,
	output decode_pkg::word_t     rdata2_o
);

	decode_pkg::word_t regs [decode_pkg::NUM_REGS];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < decode_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_i.we && wb_i.waddr != '0) begin
			regs[wb_i.waddr] <= wb_i.wdata;
		end
	end

	// r0 is hardwired, a pending writeback bypasses the array
	function automatic decode_pkg::word_t read_port(decode_pkg::reg_addr_t addr);
		if (addr == '0)
			return '0;
		if (wb_i.we && wb_i.waddr == addr)
			return wb_i.wdata;
		return regs[addr];
	endfunction

	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

endmodule

/* design/decode_stage.sv */
module decode_stage (
	input  logic                clk_i,
	input  logic                rst_i,
	input  decode_pkg::word_t   pc_i,
	input  decode_pkg::inst_u   inst_i,
	input  logic                in_delayslot_i,
	input  decode_pkg::fwd_t    ex_fwd_i,
	input  decode_pkg::fwd_t    mem_fwd_i,
	input  decode_pkg::wb_t     wb_i,
	output decode_pkg::branch_t branch_o,
	output decode_pkg::id_ex_t  id_ex_o
);

	decode_pkg::dec_ctrl_t ctrl;
	decode_pkg::word_t     rdata1;
	decode_pkg::word_t     rdata2;
	decode_pkg::word_t     reg1;
	decode_pkg::word_t     reg2;
	decode_pkg::word_t     link_addr;

	instr_decoder i_instr_decoder (
		.inst_i (inst_i),
		.ctrl_o (ctrl)
	);

	reg_file i_reg_file (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.wb_i     (wb_i),
		.raddr1_i (ctrl.reg1_addr),
		.raddr2_i (ctrl.reg2_addr),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	operand_select i_operand_select (
		.ctrl_i    (ctrl),
		.rdata1_i  (rdata1),
		.rdata2_i  (rdata2),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.reg1_o    (reg1),
		.reg2_o    (reg2)
	);

	branch_unit i_branch_unit (
		.pc_i        (pc_i),
		.inst_i      (inst_i),
		.ctrl_i      (ctrl),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.branch_o    (branch_o),
		.link_addr_o (link_addr)
	);

	// ID/EX register
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			// all zero is a NOP with no write
			id_ex_o <= '0;
		end else begin
			id_ex_o <= '{
				aluop:        ctrl.aluop,
				alusel:       ctrl.alusel,
				reg1:         reg1,
				reg2:         reg2,
				wd:           ctrl.wd,
				wreg:         ctrl.wreg,
				link_addr:    link_addr,
				in_delayslot: in_delayslot_i
			};
		end
	end

endmodule

/* include/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [31:0] xorshift32(logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic decode_pkg::word_t rtype_word(logic [5:0] fn, decode_pkg::reg_addr_t rs,
		decode_pkg::reg_addr_t rt, decode_pkg::reg_addr_t rd, logic [4:0] sh);
	return {decode_pkg::OP_SPECIAL, rs, rt, rd, sh, fn};
endfunction

function automatic decode_pkg::word_t itype_word(logic [5:0] op, decode_pkg::reg_addr_t rs,
		decode_pkg::reg_addr_t rt, logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic decode_pkg::word_t jtype_word(logic [5:0] op, logic [25:0] index);
	return {op, index};
endfunction

function automatic decode_pkg::alu_sel_e result_class(decode_pkg::alu_op_e op);
	case (op)
		decode_pkg::ALU_NOP:
			return decode_pkg::SEL_NOP;
		decode_pkg::ALU_AND, decode_pkg::ALU_OR, decode_pkg::ALU_XOR, decode_pkg::ALU_NOR:
			return decode_pkg::SEL_LOGIC;
		decode_pkg::ALU_SLL, decode_pkg::ALU_SRL, decode_pkg::ALU_SRA:
			return decode_pkg::SEL_SHIFT;
		decode_pkg::ALU_ADD, decode_pkg::ALU_ADDU, decode_pkg::ALU_SUB, decode_pkg::ALU_SUBU,
		decode_pkg::ALU_SLT, decode_pkg::ALU_SLTU:
			return decode_pkg::SEL_ARITH;
		default:
			return decode_pkg::SEL_JUMP_BRANCH;
	endcase
endfunction

// execute, then memory, then register file with same-cycle writeback
function automatic decode_pkg::word_t operand_value(logic rd_en, decode_pkg::reg_addr_t a,
		decode_pkg::word_t imm, decode_pkg::word_t regs [32], decode_pkg::fwd_t ex,
		decode_pkg::fwd_t mem, decode_pkg::wb_t wb);
	if (!rd_en)
		return imm;
	if (ex.wreg && ex.wd == a)
		return ex.wdata;
	if (mem.wreg && mem.wd == a)
		return mem.wdata;
	if (a == 5'd0)
		return 32'h0;
	if (wb.we && wb.waddr == a)
		return wb.wdata;
	return regs[a];
endfunction

function automatic void expected_decode(input decode_pkg::word_t inst,
		input decode_pkg::word_t pc, input logic ds, input decode_pkg::word_t regs [32],
		input decode_pkg::fwd_t ex, input decode_pkg::fwd_t mem, input decode_pkg::wb_t wb,
		output decode_pkg::branch_t br, output decode_pkg::id_ex_t ie);
	logic [5:0]           op;
	logic [5:0]           fn;
	logic [15:0]          imm16;
	logic                 rd1;
	logic                 rd2;
	logic                 wreg;
	logic                 link;
	logic                 taken;
	decode_pkg::reg_addr_t wd;
	decode_pkg::word_t    imm;
	decode_pkg::word_t    r1;
	decode_pkg::word_t    r2;
	decode_pkg::word_t    pc4;
	decode_pkg::word_t    target;
	decode_pkg::alu_op_e  aop;
	decode_pkg::br_kind_e kind;

	op    = inst[31:26];
	fn    = inst[5:0];
	imm16 = inst[15:0];
	rd1   = 1'b0;
	rd2   = 1'b0;
	wreg  = 1'b0;
	link  = 1'b0;
	wd    = inst[15:11];
	imm   = 32'h0;
	aop   = decode_pkg::ALU_NOP;
	kind  = decode_pkg::BR_NONE;

	case (op)
		decode_pkg::OP_SPECIAL: begin
			case (fn)
				decode_pkg::FN_SLL, decode_pkg::FN_SLLV: aop = decode_pkg::ALU_SLL;
				decode_pkg::FN_SRL, decode_pkg::FN_SRLV: aop = decode_pkg::ALU_SRL;
				decode_pkg::FN_SRA, decode_pkg::FN_SRAV: aop = decode_pkg::ALU_SRA;
				decode_pkg::FN_AND:  aop = decode_pkg::ALU_AND;
				decode_pkg::FN_OR:   aop = decode_pkg::ALU_OR;
				decode_pkg::FN_XOR:  aop = decode_pkg::ALU_XOR;
				decode_pkg::FN_NOR:  aop = decode_pkg::ALU_NOR;
				decode_pkg::FN_ADD:  aop = decode_pkg::ALU_ADD;
				decode_pkg::FN_ADDU: aop = decode_pkg::ALU_ADDU;
				decode_pkg::FN_SUB:  aop = decode_pkg::ALU_SUB;
				decode_pkg::FN_SUBU: aop = decode_pkg::ALU_SUBU;
				decode_pkg::FN_SLT:  aop = decode_pkg::ALU_SLT;
				decode_pkg::FN_SLTU: aop = decode_pkg::ALU_SLTU;
				decode_pkg::FN_JR: begin
					aop  = decode_pkg::ALU_JR;
					kind = decode_pkg::BR_JUMP_REG;
				end
				decode_pkg::FN_JALR: begin
					aop  = decode_pkg::ALU_JALR;
					kind = decode_pkg::BR_JUMP_REG;
					link = 1'b1;
				end
				default: ;
			endcase
			// constant shifts: amount as reg1, rt as reg2
			if (fn inside {decode_pkg::FN_SLL, decode_pkg::FN_SRL, decode_pkg::FN_SRA}) begin
				rd2 = 1'b1;
				imm = {27'h0, inst[10:6]};
			end else if (kind != decode_pkg::BR_NONE) begin
				rd1 = 1'b1;
			end else if (aop != decode_pkg::ALU_NOP) begin
				rd1 = 1'b1;
				rd2 = 1'b1;
			end
			wreg = (aop != decode_pkg::ALU_NOP) && (aop != decode_pkg::ALU_JR);
		end
		decode_pkg::OP_REGIMM: begin
			case (inst[20:16])
				decode_pkg::RT_BLTZ: begin
					aop  = decode_pkg::ALU_BLTZ;
					kind = decode_pkg::BR_LTZ;
				end
				decode_pkg::RT_BGEZ: begin
					aop  = decode_pkg::ALU_BGEZ;
					kind = decode_pkg::BR_GEZ;
				end
				decode_pkg::RT_BLTZAL: begin
					aop  = decode_pkg::ALU_BLTZAL;
					kind = decode_pkg::BR_LTZ;
					link = 1'b1;
				end
				decode_pkg::RT_BGEZAL: begin
					aop  = decode_pkg::ALU_BGEZAL;
					kind = decode_pkg::BR_GEZ;
					link = 1'b1;
				end
				default: ;
			endcase
			rd1 = (kind != decode_pkg::BR_NONE);
		end
		decode_pkg::OP_J: begin
			aop  = decode_pkg::ALU_J;
			kind = decode_pkg::BR_JUMP;
		end
		decode_pkg::OP_JAL: begin
			aop  = decode_pkg::ALU_JAL;
			kind = decode_pkg::BR_JUMP;
			link = 1'b1;
		end
		decode_pkg::OP_BEQ: begin
			aop  = decode_pkg::ALU_BEQ;
			kind = decode_pkg::BR_EQ;
			rd1  = 1'b1;
			rd2  = 1'b1;
		end
		decode_pkg::OP_BNE: begin
			aop  = decode_pkg::ALU_BNE;
			kind = decode_pkg::BR_NE;
			rd1  = 1'b1;
			rd2  = 1'b1;
		end
		decode_pkg::OP_BGTZ: begin
			aop  = decode_pkg::ALU_BGTZ;
			kind = decode_pkg::BR_GTZ;
			rd1  = 1'b1;
		end
		decode_pkg::OP_BLEZ: begin
			aop  = decode_pkg::ALU_BLEZ;
			kind = decode_pkg::BR_LEZ;
			rd1  = 1'b1;
		end
		decode_pkg::OP_ANDI: begin
			aop = decode_pkg::ALU_AND;
			imm = {16'h0, imm16};
		end
		decode_pkg::OP_ORI: begin
			aop = decode_pkg::ALU_OR;
			imm = {16'h0, imm16};
		end
		decode_pkg::OP_XORI: begin
			aop = decode_pkg::ALU_XOR;
			imm = {16'h0, imm16};
		end
		decode_pkg::OP_LUI: begin
			aop = decode_pkg::ALU_OR;
			imm = {imm16, 16'h0};
		end
		decode_pkg::OP_ADDI: begin
			aop = decode_pkg::ALU_ADD;
			imm = {{16{imm16[15]}}, imm16};
		end
		decode_pkg::OP_ADDIU: begin
			aop = decode_pkg::ALU_ADDU;
			imm = {{16{imm16[15]}}, imm16};
		end
		decode_pkg::OP_SLTI: begin
			aop = decode_pkg::ALU_SLT;
			imm = {{16{imm16[15]}}, imm16};
		end
		decode_pkg::OP_SLTIU: begin
			aop = decode_pkg::ALU_SLTU;
			imm = {{16{imm16[15]}}, imm16};
		end
		default: ;
	endcase

	if (op inside {decode_pkg::OP_ADDI, decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI,
			decode_pkg::OP_SLTIU, decode_pkg::OP_ANDI, decode_pkg::OP_ORI,
			decode_pkg::OP_XORI, decode_pkg::OP_LUI}) begin
		rd1  = 1'b1;
		wreg = 1'b1;
		wd   = inst[20:16];
	end
	// JALR keeps rd, the others link into r31
	if (link) begin
		wreg = 1'b1;
		if (op != decode_pkg::OP_SPECIAL)
			wd = decode_pkg::LINK_REG;
	end

	r1     = operand_value(rd1, inst[25:21], imm, regs, ex, mem, wb);
	r2     = operand_value(rd2, inst[20:16], imm, regs, ex, mem, wb);
	pc4    = pc + 32'd4;
	target = pc4 + {{14{imm16[15]}}, imm16, 2'b00};
	case (kind)
		decode_pkg::BR_JUMP: begin
			taken  = 1'b1;
			target = {pc4[31:28], inst[25:0], 2'b00};
		end
		decode_pkg::BR_JUMP_REG: begin
			taken  = 1'b1;
			target = r1;
		end
		decode_pkg::BR_EQ:  taken = (r1 == r2);
		decode_pkg::BR_NE:  taken = (r1 != r2);
		decode_pkg::BR_GTZ: taken = ($signed(r1) > 0);
		decode_pkg::BR_LEZ: taken = ($signed(r1) <= 0);
		decode_pkg::BR_GEZ: taken = ($signed(r1) >= 0);
		decode_pkg::BR_LTZ: taken = ($signed(r1) < 0);
		default:            taken = 1'b0;
	endcase

	br.flag              = taken;
	br.addr              = taken ? target : 32'h0;
	br.next_in_delayslot = taken;

	ie.aluop        = aop;
	ie.alusel       = result_class(aop);
	ie.reg1         = r1;
	ie.reg2         = r2;
	ie.wd           = wd;
	ie.wreg         = wreg;
	ie.link_addr    = link ? pc + 32'd8 : 32'h0;
	ie.in_delayslot = ds;
endfunction

`endif

/* test/tb_decode_stage.sv */
module tb_decode_stage;

	timeunit 1ns;
	timeprecision 1ps;

	`include "tb_ref_model.svh"

	localparam int RESET_CYCLES = 16;
	localparam int LEN_REGS     = 25;
	localparam int LEN_IMM      = 19;
	localparam int LEN_SHIFT    = 15;
	localparam int LEN_FWD      = 43;
	localparam int LEN_BRANCH   = 43;
	localparam int LEN_JUMP     = 27;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + LEN_REGS + LEN_IMM + LEN_SHIFT + LEN_FWD
		+ LEN_BRANCH + LEN_JUMP + 100;

	// opcode 111111 is not decoded
	localparam decode_pkg::word_t IDLE_INST = 32'hfc00_0000;

	localparam logic [5:0] RTYPE_FNS [10] = '{
		decode_pkg::FN_AND, decode_pkg::FN_OR, decode_pkg::FN_XOR, decode_pkg::FN_NOR,
		decode_pkg::FN_ADD, decode_pkg::FN_ADDU, decode_pkg::FN_SUB, decode_pkg::FN_SUBU,
		decode_pkg::FN_SLT, decode_pkg::FN_SLTU
	};
	localparam logic [5:0] IMM_OPS [8] = '{
		decode_pkg::OP_ORI, decode_pkg::OP_ANDI, decode_pkg::OP_XORI, decode_pkg::OP_LUI,
		decode_pkg::OP_ADDI, decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI, decode_pkg::OP_SLTIU
	};
	localparam logic [5:0] SHIFT_FNS [6] = '{
		decode_pkg::FN_SLL, decode_pkg::FN_SRL, decode_pkg::FN_SRA,
		decode_pkg::FN_SLLV, decode_pkg::FN_SRLV, decode_pkg::FN_SRAV
	};

	logic                clk = 1'b0;
	logic                rst;
	decode_pkg::word_t   pc;
	decode_pkg::word_t   inst;
	logic                in_ds;
	decode_pkg::fwd_t    ex_fwd;
	decode_pkg::fwd_t    mem_fwd;
	decode_pkg::wb_t     wb;
	decode_pkg::branch_t branch;
	decode_pkg::id_ex_t  id_ex;

	decode_pkg::word_t   shadow [32];
	decode_pkg::branch_t br_at_edge;
	decode_pkg::id_ex_t  exp_ie;
	logic [31:0]         rng_state = 32'd63;
	string               test_name = "reset";
	int                  test_errors_start = 0;
	int                  checks = 0;
	int                  errors = 0;
	int                  cycles = 0;

	decode_stage i_decode_stage (
		.clk_i          (clk),
		.rst_i          (rst),
		.pc_i           (pc),
		.inst_i         (inst),
		.in_delayslot_i (in_ds),
		.ex_fwd_i       (ex_fwd),
		.mem_fwd_i      (mem_fwd),
		.wb_i           (wb),
		.branch_o       (branch),
		.id_ex_o        (id_ex)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic decode_pkg::wb_t wb_port(logic we, decode_pkg::reg_addr_t a,
			decode_pkg::word_t d);
		decode_pkg::wb_t w;
		w.we    = we;
		w.waddr = a;
		w.wdata = d;
		return w;
	endfunction

	function automatic decode_pkg::fwd_t fwd_src(logic en, decode_pkg::reg_addr_t a,
			decode_pkg::word_t d);
		decode_pkg::fwd_t f;
		f.wreg  = en;
		f.wd    = a;
		f.wdata = d;
		return f;
	endfunction

	task automatic check(string what, logic [127:0] exp, logic [127:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	// expected outputs and shadow registers follow each rising edge
	always @(posedge clk) begin
		if (rst) begin
			exp_ie = '0;
			for (int r = 0; r < 32; r++)
				shadow[r] = 32'h0;
		end else begin
			expected_decode(inst, pc, in_ds, shadow, ex_fwd, mem_fwd, wb, br_at_edge, exp_ie);
			if (wb.we && wb.waddr != 5'd0)
				shadow[wb.waddr] = wb.wdata;
		end
	end

	// inputs still hold the values seen at the last rising edge
	always @(negedge clk) begin
		check("id_ex", 128'(exp_ie), 128'(id_ex));
		if (!rst)
			check("branch", 128'(br_at_edge), 128'(branch));
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic apply(decode_pkg::word_t i, decode_pkg::word_t p, logic ds,
			decode_pkg::fwd_t ex, decode_pkg::fwd_t mem, decode_pkg::wb_t w);
		@(negedge clk);
		inst    <= i;
		pc      <= p;
		in_ds   <= ds;
		ex_fwd  <= ex;
		mem_fwd <= mem;
		wb      <= w;
	endtask

	task automatic begin_test(string name);
		test_name         = name;
		test_errors_start = errors;
	endtask

	task automatic end_test();
		apply(IDLE_INST, 32'h0, 1'b0, '0, '0, '0);
		// last instruction reaches id_ex and gets checked
		repeat (2) @(posedge clk);
		$display("%s done, %0d errors", test_name, errors - test_errors_start);
	endtask

	task automatic test_reg_ops();
		logic [31:0] r;
		begin_test("reg_ops");
		for (int a = 1; a <= 8; a++)
			apply(IDLE_INST, 32'h0, 1'b0, '0, '0, wb_port(1'b1, 5'(a), rand_word()));
		// a write to r0 must not stick
		apply(IDLE_INST, 32'h0, 1'b0, '0, '0, wb_port(1'b1, 5'd0, 32'hdead_beef));
		apply(rtype_word(decode_pkg::FN_OR, 5'd0, 5'd0, 5'd2, 5'd0), 32'h0, 1'b0, '0, '0, '0);
		for (int k = 0; k < 12; k++) begin
			r = rand_word();
			apply(rtype_word(RTYPE_FNS[r % 10], 5'(r[7:4] % 9), 5'(r[11:8] % 9), r[16:12],
				5'd0), 32'h0, 1'b0, '0, '0, '0);
		end
		end_test();
	endtask

	task automatic test_immediates();
		logic [31:0] r;
		logic [5:0]  op;
		begin_test("immediates");
		for (int k = 0; k < 16; k++) begin
			r  = rand_word();
			op = IMM_OPS[k % 8];
			apply(itype_word(op, (op == decode_pkg::OP_LUI) ? 5'd0 : r[20:16], r[25:21],
				r[15:0]), 32'h0, 1'b0, '0, '0, '0);
		end
		end_test();
	endtask

	task automatic test_shifts();
		logic [31:0]       r;
		logic [5:0]        fn;
		decode_pkg::word_t w;
		begin_test("shifts");
		for (int k = 0; k < 12; k++) begin
			r  = rand_word();
			fn = SHIFT_FNS[k % 6];
			if (k % 6 < 3)
				w = rtype_word(fn, 5'd0, r[20:16], r[15:11], r[10:6]);
			else
				w = rtype_word(fn, r[25:21], r[20:16], r[15:11], 5'd0);
			apply(w, 32'h0, 1'b0, '0, '0, '0);
		end
		end_test();
	endtask

	task automatic test_forwarding();
		logic [31:0] r;
		logic [31:0] d1;
		logic [31:0] d2;
		logic [31:0] d3;
		begin_test("forwarding");
		// small address pool so the sources collide often
		for (int k = 0; k < 40; k++) begin
			r  = rand_word();
			d1 = rand_word();
			d2 = rand_word();
			d3 = rand_word();
			apply(rtype_word(decode_pkg::FN_ADDU, 5'(r[1:0]), 5'(r[3:2]), r[8:4], 5'd0),
				32'h0, 1'b0, fwd_src(r[9], 5'(r[11:10]), d1),
				fwd_src(r[12], 5'(r[14:13]), d2), wb_port(r[15], 5'(r[17:16]), d3));
		end
		end_test();
	endtask

	task automatic test_branches();
		logic [31:0]           r;
		logic [31:0]           d;
		logic [31:0]           p;
		decode_pkg::reg_addr_t rs;
		decode_pkg::word_t     w;
		begin_test("branches");
		for (int k = 0; k < 40; k++) begin
			r = rand_word();
			d = (r[31:30] == 2'b00) ? 32'h0 : rand_word();
			p = rand_word();
			p[1:0] = 2'b00;
			rs = 5'(r[1:0]);
			case (r[24:22])
				3'd0: w = itype_word(decode_pkg::OP_BEQ, rs, 5'(r[3:2]), r[21:6]);
				3'd1: w = itype_word(decode_pkg::OP_BNE, rs, 5'(r[3:2]), r[21:6]);
				3'd2: w = itype_word(decode_pkg::OP_BGTZ, rs, 5'd0, r[21:6]);
				3'd3: w = itype_word(decode_pkg::OP_BLEZ, rs, 5'd0, r[21:6]);
				3'd4: w = itype_word(decode_pkg::OP_REGIMM, rs, decode_pkg::RT_BGEZ, r[21:6]);
				default: w = itype_word(decode_pkg::OP_REGIMM, rs, decode_pkg::RT_BLTZ, r[21:6]);
			endcase
			apply(w, p, r[25], '0, '0, wb_port(1'b1, 5'(r[5:4]), d));
		end
		end_test();
	endtask

	task automatic test_jumps();
		logic [31:0]       r;
		logic [31:0]       d;
		logic [31:0]       p;
		decode_pkg::word_t w;
		begin_test("jumps");
		for (int k = 0; k < 24; k++) begin
			r = rand_word();
			d = rand_word();
			p = rand_word();
			p[1:0] = 2'b00;
			case (k % 6)
				0: w = jtype_word(decode_pkg::OP_J, d[25:0]);
				1: w = jtype_word(decode_pkg::OP_JAL, d[25:0]);
				2: w = rtype_word(decode_pkg::FN_JR, r[4:0], 5'd0, 5'd0, 5'd0);
				3: w = rtype_word(decode_pkg::FN_JALR, r[4:0], 5'd0, r[9:5], 5'd0);
				4: w = itype_word(decode_pkg::OP_REGIMM, r[4:0], decode_pkg::RT_BGEZAL, d[15:0]);
				default: w = itype_word(decode_pkg::OP_REGIMM, r[4:0], decode_pkg::RT_BLTZAL,
					d[15:0]);
			endcase
			apply(w, p, r[10], '0, '0, '0);
		end
		end_test();
	endtask

	initial begin
		rst     = 1'b1;
		pc      = 32'h0;
		inst    = IDLE_INST;
		in_ds   = 1'b0;
		ex_fwd  = '0;
		mem_fwd = '0;
		wb      = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst <= 1'b0;

		test_reg_ops();
		test_immediates();
		test_shifts();
		test_forwarding();
		test_branches();
		test_jumps();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+include
design/decode_pkg.sv
design/instr_decoder.sv
design/operand_select.sv
design/branch_unit.sv
design/reg_file.sv
design/decode_stage.sv
test/tb_decode_stage.sv

/* run.sh */
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_decode_stage -o sim_decode_stage
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_decode_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
